// ==== muldiv_cfg.svh ====
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// data path width
`define MULDIV_XLEN 32

// multiplier bits per pipe stage (4, 8 or 16)
`define MULDIV_MUL_UNROLL 8

// rename tag width
`define MULDIV_RNID_W 6

// reservation station entries, one-hot index width
`define MULDIV_RS_ENTRIES 8

`endif

// ==== riscv_op_pkg.sv ====
`include "muldiv_cfg.svh"

package riscv_op_pkg;

  typedef logic [`MULDIV_XLEN-1:0] xword_t;

  // M-extension ops, low three bits follow funct3
  typedef enum logic [3:0] {
    OP_MUL    = 4'h0,
    OP_MULH   = 4'h1,
    OP_MULHSU = 4'h2,
    OP_MULHU  = 4'h3,
    OP_DIV    = 4'h4,
    OP_DIVU   = 4'h5,
    OP_REM    = 4'h6,
    OP_REMU   = 4'h7,
    OP_NONE   = 4'hf
  } op_t;

  function automatic logic op_is_mul(op_t op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  endfunction

  function automatic logic op_is_div(op_t op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

endpackage

// ==== muldiv_pkg.sv ====
`include "muldiv_cfg.svh"

package muldiv_pkg;

  // ====================================================================
  // destination tag, passed through untouched
  // ====================================================================

  typedef struct packed {
    logic [`MULDIV_RNID_W-1:0]     rnid;
    logic                          reg_type;  // 0 gpr, 1 fpr
    logic [`MULDIV_RS_ENTRIES-1:0] index_oh;
  } dest_tag_t;

  // ====================================================================
  // request and result
  // ====================================================================

  typedef struct packed {
    riscv_op_pkg::op_t    op;
    riscv_op_pkg::xword_t rs1;
    riscv_op_pkg::xword_t rs2;
    dest_tag_t            dest;
  } muldiv_req_t;

  typedef struct packed {
    riscv_op_pkg::xword_t data;
    dest_tag_t            dest;
  } muldiv_res_t;

endpackage

// ==== mul_pipe.sv ====
`include "muldiv_cfg.svh"

module mul_pipe (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_valid,
  input  muldiv_pkg::muldiv_req_t i_req,
  output logic                    o_valid,
  output muldiv_pkg::muldiv_res_t o_res
);
  import riscv_op_pkg::*;
  import muldiv_pkg::*;

  localparam int XLEN     = `MULDIV_XLEN;
  localparam int UNROLL   = `MULDIV_MUL_UNROLL;
  localparam int MUL_STEP = (XLEN + UNROLL - 1) / UNROLL;
  localparam int B_W      = MUL_STEP * UNROLL + 1;  // extended multiplier
  localparam int PP_W     = XLEN + UNROLL + 2;      // partial product
  localparam int PROD_W   = 2 * XLEN;

  logic              w_a_sgn;
  logic              w_b_sgn;
  logic [XLEN:0]     w_a_ext;
  logic [B_W-1:0]    w_b_ext;
  logic [PROD_W-1:0] w_acc [MUL_STEP];

  logic [MUL_STEP:1] r_valid;
  op_t               r_op   [1:MUL_STEP];
  dest_tag_t         r_dest [1:MUL_STEP];
  logic [PROD_W-1:0] r_acc  [1:MUL_STEP];
  logic [XLEN:0]     r_a    [1:MUL_STEP-1];
  logic [B_W-1:0]    r_b    [1:MUL_STEP-1];

  // ====================================================================
  // operand extension
  // ====================================================================

  assign w_a_sgn = i_req.op inside {OP_MUL, OP_MULH, OP_MULHSU};
  assign w_b_sgn = i_req.op inside {OP_MUL, OP_MULH};
  assign w_a_ext = {w_a_sgn & i_req.rs1[XLEN-1], i_req.rs1};
  assign w_b_ext = {{(B_W-XLEN){w_b_sgn & i_req.rs2[XLEN-1]}}, i_req.rs2};

  // ====================================================================
  // partial product per stage
  // ====================================================================

  for (genvar s = 0; s < MUL_STEP; s++) begin : g_stage
    logic [XLEN:0]     w_a;
    logic [B_W-1:0]    w_b;
    logic [UNROLL:0]   w_chunk;
    logic [PP_W-1:0]   w_pp;
    logic [PROD_W-1:0] w_pp_ext;

    if (s == 0) begin : g_first
      assign w_a      = w_a_ext;
      assign w_b      = w_b_ext;
      assign w_acc[s] = w_pp_ext << (UNROLL * s);
    end else begin : g_next
      assign w_a      = r_a[s];
      assign w_b      = r_b[s];
      assign w_acc[s] = r_acc[s] + (w_pp_ext << (UNROLL * s));
    end

    if (s == MUL_STEP - 1) begin : g_top
      assign w_chunk = w_b[UNROLL*s +: UNROLL+1];  // carries the sign bit
    end else begin : g_low
      assign w_chunk = {1'b0, w_b[UNROLL*s +: UNROLL]};
    end

    assign w_pp     = $signed(w_a) * $signed(w_chunk);
    assign w_pp_ext = {{(PROD_W-PP_W){w_pp[PP_W-1]}}, w_pp};
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      r_valid <= {r_valid[MUL_STEP-1:1], i_valid};
    end
  end

  always_ff @(posedge i_clk) begin
    r_op[1]   <= i_req.op;
    r_dest[1] <= i_req.dest;
    r_acc[1]  <= w_acc[0];
    r_a[1]    <= w_a_ext;
    r_b[1]    <= w_b_ext;
    for (int s = 1; s < MUL_STEP; s++) begin
      r_op[s+1]   <= r_op[s];
      r_dest[s+1] <= r_dest[s];
      r_acc[s+1]  <= w_acc[s];
    end
    for (int s = 1; s < MUL_STEP - 1; s++) begin
      r_a[s+1] <= r_a[s];
      r_b[s+1] <= r_b[s];
    end
  end

  assign o_valid    = r_valid[MUL_STEP];
  assign o_res.dest = r_dest[MUL_STEP];
  assign o_res.data = (r_op[MUL_STEP] == OP_MUL) ? r_acc[MUL_STEP][XLEN-1:0] :
                                                   r_acc[MUL_STEP][PROD_W-1:XLEN];

endmodule

// ==== div_unit.sv ====
`include "muldiv_cfg.svh"

module div_unit (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_valid,
  input  muldiv_pkg::muldiv_req_t i_req,
  output logic                    o_busy,
  output logic                    o_valid,
  output muldiv_pkg::muldiv_res_t o_res,
  input  logic                    i_ready
);
  import riscv_op_pkg::*;
  import muldiv_pkg::*;

  localparam int XLEN  = `MULDIV_XLEN;
  localparam int CNT_W = $clog2(XLEN + 1);

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

  state_t           r_state;
  logic [CNT_W-1:0] r_cnt;
  xword_t           r_quo;
  xword_t           r_rem;
  xword_t           r_dvs;
  logic             r_is_rem;
  logic             r_neg_quo;
  logic             r_neg_rem;
  logic             r_dvs_zero;
  muldiv_res_t      r_res;

  logic             w_start;
  logic             w_sgn;
  logic             w_rs1_neg;
  logic             w_rs2_neg;
  xword_t           w_rs1_mag;
  xword_t           w_rs2_mag;
  logic [XLEN:0]    w_rem_shift;
  logic [XLEN:0]    w_diff;
  xword_t           w_quo_fix;
  xword_t           w_rem_fix;

  assign w_start   = (r_state == IDLE) & i_valid;
  assign w_sgn     = i_req.op inside {OP_DIV, OP_REM};
  assign w_rs1_neg = w_sgn & i_req.rs1[XLEN-1];
  assign w_rs2_neg = w_sgn & i_req.rs2[XLEN-1];
  assign w_rs1_mag = w_rs1_neg ? -i_req.rs1 : i_req.rs1;
  assign w_rs2_mag = w_rs2_neg ? -i_req.rs2 : i_req.rs2;

  // ====================================================================
  // control
  // ====================================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        IDLE: if (i_valid) begin
          r_state <= RUN;
          r_cnt   <= '0;
        end
        RUN: if (r_cnt == CNT_W'(XLEN)) r_state <= DONE;  // last cycle fixes signs
             else r_cnt <= r_cnt + 1'b1;
        DONE: if (i_ready) r_state <= IDLE;
        default: r_state <= IDLE;
      endcase
    end
  end

  // ====================================================================
  // restoring divide on magnitudes
  // ====================================================================

  assign w_rem_shift = {r_rem, r_quo[XLEN-1]};
  assign w_diff      = w_rem_shift - {1'b0, r_dvs};

  // most negative / -1 already lands on rs1 and zero here
  assign w_quo_fix = r_dvs_zero ? '1 : (r_neg_quo ? -r_quo : r_quo);
  assign w_rem_fix = r_neg_rem ? -r_rem : r_rem;

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      r_quo      <= w_rs1_mag;  // dividend shifts out as quotient shifts in
      r_rem      <= '0;
      r_dvs      <= w_rs2_mag;
      r_is_rem   <= i_req.op inside {OP_REM, OP_REMU};
      r_neg_quo  <= w_rs1_neg ^ w_rs2_neg;
      r_neg_rem  <= w_rs1_neg;
      r_dvs_zero <= (i_req.rs2 == '0);
      r_res.dest <= i_req.dest;
    end else if (r_state == RUN) begin
      if (r_cnt == CNT_W'(XLEN)) begin
        r_res.data <= r_is_rem ? w_rem_fix : w_quo_fix;
      end else begin
        r_quo <= {r_quo[XLEN-2:0], ~w_diff[XLEN]};
        r_rem <= w_diff[XLEN] ? w_rem_shift[XLEN-1:0] : w_diff[XLEN-1:0];
      end
    end
  end

  assign o_busy  = (r_state != IDLE);
  assign o_valid = (r_state == DONE);
  assign o_res   = r_res;

endmodule

// ==== muldiv_resp_merge.sv ====
module muldiv_resp_merge (
  input  logic                    i_mul_valid,
  input  muldiv_pkg::muldiv_res_t i_mul_res,
  input  logic                    i_div_valid,
  input  muldiv_pkg::muldiv_res_t i_div_res,
  output logic                    o_div_ready,
  output logic                    o_wb_valid,
  output muldiv_pkg::muldiv_res_t o_wb
);

  // ====================================================================
  // fixed priority, multiplier first
  // ====================================================================

  // pipeline has no stall, divider waits on conflict
  assign o_div_ready = ~i_mul_valid;

  always_comb begin
    o_wb_valid = 1'b0;
    o_wb       = i_div_res;
    if (i_mul_valid) begin
      o_wb_valid = 1'b1;
      o_wb       = i_mul_res;
    end else if (i_div_valid) begin
      o_wb_valid = 1'b1;
    end
  end

endmodule

// ==== muldiv_top.sv ====
module muldiv_top (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_req_valid,
  input  muldiv_pkg::muldiv_req_t i_req,
  output logic                    o_req_ready,
  output logic                    o_wb_valid,
  output muldiv_pkg::muldiv_res_t o_wb
);
  import riscv_op_pkg::*;
  import muldiv_pkg::*;

  logic        w_req_fire;
  logic        w_mul_in_valid;
  logic        w_div_in_valid;
  logic        w_div_busy;
  logic        w_mul_valid;
  logic        w_div_valid;
  logic        w_div_ready;
  muldiv_res_t w_mul_res;
  muldiv_res_t w_div_res;

  // ====================================================================
  // steering
  // ====================================================================

  assign o_req_ready    = ~w_div_busy;  // any divide in flight blocks both
  assign w_req_fire     = i_req_valid & o_req_ready;
  assign w_mul_in_valid = w_req_fire & op_is_mul(i_req.op);
  assign w_div_in_valid = w_req_fire & op_is_div(i_req.op);

  mul_pipe mul_pipe_inst (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_mul_in_valid),
    .i_req     (i_req),
    .o_valid   (w_mul_valid),
    .o_res     (w_mul_res)
  );

  div_unit div_unit_inst (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_div_in_valid),
    .i_req     (i_req),
    .o_busy    (w_div_busy),
    .o_valid   (w_div_valid),
    .o_res     (w_div_res),
    .i_ready   (w_div_ready)
  );

  muldiv_resp_merge muldiv_resp_merge_inst (
    .i_mul_valid (w_mul_valid),
    .i_mul_res   (w_mul_res),
    .i_div_valid (w_div_valid),
    .i_div_res   (w_div_res),
    .o_div_ready (w_div_ready),
    .o_wb_valid  (o_wb_valid),
    .o_wb        (o_wb)
  );

endmodule

// ==== tb_muldiv.sv ====
`include "muldiv_cfg.svh"

module tb_muldiv;
  timeunit 1ns;
  timeprecision 1ps;
  import riscv_op_pkg::*;
  import muldiv_pkg::*;

  localparam int RNID_W = `MULDIV_RNID_W;
  localparam int RS_N   = `MULDIV_RS_ENTRIES;
  localparam int TAGS   = 1 << RNID_W;
  localparam int LIMIT  = 200;  // cycles per wait

  typedef struct packed {
    op_t               op;
    xword_t            rs1;
    xword_t            rs2;
    logic [RNID_W-1:0] rnid;
    xword_t            expected;
  } trace_entry_t;

  logic i_clk, i_reset_n, i_req_valid, o_req_ready, o_wb_valid;
  muldiv_req_t  i_req;
  muldiv_res_t  o_wb;
  trace_entry_t trace_q[$];
  trace_entry_t exp_of [TAGS];
  logic issued [TAGS];
  logic written [TAGS];
  logic ready_bad [TAGS];
  int   issue_at [TAGS];
  int   cycle_cnt = 0;
  int   pass_count = 0;
  int   fail_count = 0;
  int   done_count = 0;
  logic div_open = 1'b0;
  int   div_issue_at = 0;
  logic [RNID_W-1:0] div_rnid;

  muldiv_top muldiv_top_inst (.*);

  always #20 i_clk = ~i_clk;
  always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

  function automatic dest_tag_t make_dest(logic [RNID_W-1:0] rnid);
    dest_tag_t d;
    d.rnid     = rnid;
    d.reg_type = rnid[0];
    d.index_oh = {{(RS_N-1){1'b0}}, 1'b1} << (rnid % RS_N);
    return d;
  endfunction

  function automatic logic is_mul(op_t op);
    return (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU) || (op == OP_MULHU);
  endfunction

  task automatic load_trace();
    int fd;
    string line;
    logic [31:0] f_op, f_rs1, f_rs2, f_rnid, f_exp;
    trace_entry_t e;
    fd = $fopen("muldiv_trace.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;  // column notes
      if ($sscanf(line, "%h %h %h %h %h", f_op, f_rs1, f_rs2, f_rnid, f_exp) != 5) continue;
      e = {op_t'(f_op[3:0]), f_rs1, f_rs2, f_rnid[RNID_W-1:0], f_exp};
      trace_q.push_back(e);
    end
    $fclose(fd);
  endtask

  // valid held until ready, which only moves on the rising edge
  task automatic issue_entry(input trace_entry_t e, output logic ok);
    int waited;
    waited = 0;
    exp_of[e.rnid] = e;
    i_req_valid = 1'b1;
    i_req = {e.op, e.rs1, e.rs2, make_dest(e.rnid)};
    while (!o_req_ready && waited < LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    ok = o_req_ready;
    if (!ok) begin
      $display("request rnid %h was never accepted, ready stuck low", e.rnid);
    end else begin
      issue_at[e.rnid] = cycle_cnt + 1;  // accepted on the coming edge
      issued[e.rnid]   = 1'b1;
      if (!is_mul(e.op)) begin
        div_rnid     = e.rnid;
        div_issue_at = cycle_cnt + 1;
        div_open     = 1'b1;
      end
      @(negedge i_clk);
    end
    i_req_valid = 1'b0;
  endtask

  task automatic check_writeback();
    logic [RNID_W-1:0] tag;
    logic bad;
    int   lat;
    tag = o_wb.dest.rnid;
    assert (issued[tag] && !written[tag]) else begin
      $display("writeback for rnid %h that was not issued or was already written back", tag);
      fail_count++;
      return;
    end
    written[tag] = 1'b1;
    done_count++;
    bad = ready_bad[tag];
    lat = cycle_cnt + 1 - issue_at[tag];
    assert (o_wb.data === exp_of[tag].expected) else begin
      $display("Error: o_wb.data rnid %h expected %h actual %h",
               tag, exp_of[tag].expected, o_wb.data);
      bad = 1'b1;
    end
    assert (o_wb.dest === make_dest(tag)) else begin
      $display("Error: o_wb.dest expected %h actual %h", make_dest(tag), o_wb.dest);
      bad = 1'b1;
    end
    if (is_mul(exp_of[tag].op)) begin
      assert (lat == 4) else begin
        $display("multiply rnid %h came back after %0d cycles, not 4", tag, lat);
        bad = 1'b1;
      end
    end else begin
      div_open = 1'b0;
      assert (lat >= `MULDIV_XLEN + 2) else begin
        $display("divide rnid %h came back too early, after %0d cycles", tag, lat);
        bad = 1'b1;
      end
    end
    if (bad) fail_count++;
    else pass_count++;
    $display("test rnid %h %s %s", tag, exp_of[tag].op.name(), bad ? "failed" : "passed");
  endtask

  always @(negedge i_clk) begin
    if (i_reset_n) begin
      if (div_open && div_issue_at <= cycle_cnt) begin
        assert (!o_req_ready) else begin
          $display("ready went high while divide rnid %h was in progress", div_rnid);
          ready_bad[div_rnid] = 1'b1;
        end
      end
      if (o_wb_valid) check_writeback();
    end
  end

  initial begin
    logic ok;
    logic prev_mul;
    int   waited;
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_req_valid = 1'b0;
    i_req = '0;
    ok = 1'b1;
    prev_mul = 1'b0;
    waited = 0;
    void'($urandom(32'hc113de35));
    for (int t = 0; t < TAGS; t++) begin
      issued[t] = 1'b0;
      written[t] = 1'b0;
      ready_bad[t] = 1'b0;
    end
    load_trace();
    if (trace_q.size() == 0) begin
      $display("trace file missing or empty");
      ok = 1'b0;
    end
    repeat (2) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);
    foreach (trace_q[k]) begin
      if (!ok) break;
      if (!prev_mul) repeat ($urandom % 4) @(negedge i_clk);  // multiply runs go back to back
      issue_entry(trace_q[k], ok);
      prev_mul = is_mul(trace_q[k].op);
    end
    while (ok && done_count < trace_q.size() && waited < LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (ok) begin
      assert (done_count == trace_q.size()) else begin
        $display("%0d requests were never written back", trace_q.size() - done_count);
        fail_count += trace_q.size() - done_count;
      end
    end
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (!ok || fail_count != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
riscv_op_pkg.sv
muldiv_pkg.sv
mul_pipe.sv
div_unit.sv
muldiv_resp_merge.sv
muldiv_top.sv
tb_muldiv.sv

// ==== run.sh ====
#!/bin/sh
# build and run the muldiv testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_muldiv \
  -f filelist.f -o sim_muldiv > build.log 2>&1 &&
./obj_dir/sim_muldiv > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "TEST OK" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== muldiv_trace.txt ====
# op rs1 rs2 rnid expected, all hex, one request per line
# op 0 mul 1 mulh 2 mulhsu 3 mulhu 4 div 5 divu 6 rem 7 remu
0 00000007 00000006 01 0000002a
0 ffffffff 00000005 02 fffffffb
1 ffffffff 00000005 03 ffffffff
3 ffffffff 00000005 04 00000004
2 ffffffff 00000005 05 ffffffff
2 00000005 ffffffff 06 00000004
1 80000000 80000000 07 40000000
3 ffffffff ffffffff 08 fffffffe
0 ffffffff ffffffff 09 00000001
1 00010000 fff00000 0a fffffff0
3 00010000 fff00000 0b 0000fff0
2 fff00000 00010000 0c fffffff0
0 00001234 00010000 0d 12340000
1 7fffffff 7fffffff 0e 3fffffff
2 80000000 ffffffff 0f 80000000
1 80000000 ffffffff 10 00000000
0 80000000 ffffffff 11 80000000
3 00000003 00000007 12 00000000
0 fffffffd fffffff9 13 00000015
4 00000014 00000006 14 00000003
4 ffffffec 00000006 15 fffffffd
6 ffffffec 00000006 16 fffffffe
6 00000014 fffffffa 17 00000002
5 ffffffec 00000006 18 2aaaaaa7
7 ffffffec 00000006 19 00000002
4 00001234 00000000 1a ffffffff
5 00001234 00000000 1b ffffffff
6 00001234 00000000 1c 00001234
7 ffffffec 00000000 1d ffffffec
4 80000000 ffffffff 1e 80000000
6 80000000 ffffffff 1f 00000000
4 ffffffec fffffffa 20 00000003
0 0000ffff 0000ffff 21 fffe0001
5 00000064 00000007 22 0000000e
